// File: flist.f
rtl/mem_ex_pkg.sv
rtl/queue_nm.sv
rtl/operand_wakeup.sv
rtl/mem_ex_latches.sv
dv/mem_ex_latches_chk.sv
dv/tb_mem_ex_latches.sv

// File: run.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_ex_latches \
    -Mdir obj_dir -o tb_sim -f flist.f > build.log 2>&1 || { echo "build error, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q '^sim passed$' sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: dv/tb_mem_ex_latches.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_ex_latches;

    import mem_ex_pkg::*;

    // cycle budget per test plus slack
    localparam int budget_reset = 5;
    localparam int budget_random = 220;
    localparam int budget_fill = 40;
    localparam int budget_wakeup = 30;
    localparam int budget_stale = 30;
    localparam int budget_flush = 30;
    localparam int cycle_limit = budget_reset + budget_random + budget_fill
                               + budget_wakeup + budget_stale + budget_flush + 50;

    logic clk;
    logic rst_n;
    logic clr;
    logic wr;
    logic rd;
    mod_fields_t m_din;
    fixed_fields_t n_din;
    result_t result;
    logic full;
    logic empty;
    entry_t dout;

    // reference queue with head at index 0
    entry_t model_q [$];

    logic [31:0] lfsr = 32'h395e_a624;
    int errors = 0;
    int test_mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;

    mem_ex_latches DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (clr),
        .wr    (wr),
        .rd    (rd),
        .m_din (m_din),
        .n_din (n_din),
        .result(result),
        .full  (full),
        .empty (empty),
        .dout  (dout)
    );

    // flag and pointer properties on the top level
    bind mem_ex_latches mem_ex_latches_chk u_chk (
        .clk  (clk),
        .rst_n(rst_n),
        .clr  (clr),
        .wr   (wr),
        .rd   (rd),
        .full (full),
        .empty(empty)
    );

    always #10 clk = ~clk;

    // hard stop
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < n; b++) begin
            w = {w[30:0], rand_bit()};
        end
        return w;
    endfunction

    // every field random with valid forced
    function automatic entry_t rand_entry();
        entry_t e;
        for (int b = 0; b < $bits(entry_t); b++) begin
            e[b] = rand_bit();
        end
        e.m.valid = 1'b1;
        return e;
    endfunction

    // push, pop, wakeup and clear rules applied at the edge
    task automatic update_model();
        entry_t e;
        logic was_full;
        logic was_empty;
        was_full = (model_q.size() == q_length);
        was_empty = (model_q.size() == 0);
        if (!rst_n || clr) begin
            model_q.delete();
        end else begin
            // broadcast only reaches entries already stored
            if (result.valid) begin
                for (int k = 0; k < model_q.size(); k++) begin
                    e = model_q[k];
                    for (int j = 0; j < n_ops; j++) begin
                        if (e.m.wake[j] && (e.m.op_tag[j] == result.tag)) begin
                            e.m.op_val[j] = result.value;
                            e.m.wake[j] = 1'b0;
                        end
                    end
                    model_q[k] = e;
                end
            end
            if (rd && !was_empty) begin
                void'(model_q.pop_front());
            end
            // full refuses the push even with a pop
            if (wr && !was_full) begin
                e.m = m_din;
                e.n = n_din;
                model_q.push_back(e);
            end
        end
    endtask

    task automatic compare_outputs();
        logic exp_empty;
        logic exp_full;
        exp_empty = (model_q.size() == 0);
        exp_full = (model_q.size() == q_length);
        assert (empty === exp_empty) else begin
            $display("ERROR empty expected %h actual %h", exp_empty, empty);
            errors++;
        end
        assert (full === exp_full) else begin
            $display("ERROR full expected %h actual %h", exp_full, full);
            errors++;
        end
        // head only meaningful when something is stored
        if (!exp_empty) begin
            assert (dout === model_q[0]) else begin
                $display("ERROR dout expected %h actual %h", model_q[0], dout);
                errors++;
            end
        end
    endtask

    // one clock with the model update at the edge
    // compare at +1 ns and new drive at +2 ns
    task automatic tick();
        @(posedge clk);
        update_model();
        #1;
        compare_outputs();
        #1;
        wr = 1'b0;
        rd = 1'b0;
        clr = 1'b0;
        result = '0;
    endtask

    task automatic push(input entry_t e);
        wr = 1'b1;
        m_din = e.m;
        n_din = e.n;
    endtask

    task automatic broadcast(input logic [tag_w-1:0] t, input logic [val_w-1:0] v);
        result.valid = 1'b1;
        result.tag = t;
        result.value = v;
    endtask

    task automatic drain();
        while (model_q.size() != 0) begin
            rd = 1'b1;
            tick();
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_mark) begin
            tests_ok++;
            $display("test %s done, no errors", name);
        end else begin
            tests_bad++;
            $display("test %s done, %0d errors", name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    // mixed push and pop
    // wr more likely so full is reached
    task automatic random_traffic();
        for (int c = 0; c < 200; c++) begin
            if (rand_bit() || rand_bit()) begin
                push(rand_entry());
            end
            rd = rand_bit();
            tick();
        end
        drain();
    endtask

    task automatic fill_and_drain();
        for (int k = 0; k < q_length; k++) begin
            push(rand_entry());
            tick();
        end
        assert (full === 1'b1) else begin
            $display("ERROR full expected %h actual %h", 1'b1, full);
            errors++;
        end
        // ninth write is lost
        push(rand_entry());
        tick();
        // at full only the pop lands
        push(rand_entry());
        rd = 1'b1;
        tick();
        push(rand_entry());
        tick();
        drain();
        // pop of an empty queue
        rd = 1'b1;
        tick();
    endtask

    // several entries wait on one tag
    // a single broadcast wakes them all
    task automatic broadcast_wakeup();
        entry_t sent [6];
        logic [tag_w-1:0] t;
        logic [val_w-1:0] v;
        t = tag_w'(rand_word(tag_w));
        v = rand_word(val_w);
        for (int k = 0; k < 6; k++) begin
            sent[k] = rand_entry();
            if (k % 2 == 0) begin
                sent[k].m.op_tag[k % n_ops] = t;
                sent[k].m.wake[k % n_ops] = 1'b1;
            end
            // two waiting operands in the first entry
            if (k == 0) begin
                sent[k].m.op_tag[3] = t;
                sent[k].m.wake[3] = 1'b1;
            end
            push(sent[k]);
            tick();
        end
        broadcast(t, v);
        tick();
        for (int k = 0; k < 6; k++) begin
            for (int j = 0; j < n_ops; j++) begin
                if (sent[k].m.wake[j] && (sent[k].m.op_tag[j] == t)) begin
                    assert ((dout.m.op_val[j] === v) && (dout.m.wake[j] === 1'b0)) else begin
                        $display("ERROR dout.m.op_val[%0d] expected %h actual %h wake %h",
                                 j, v, dout.m.op_val[j], dout.m.wake[j]);
                        errors++;
                    end
                end
            end
            rd = 1'b1;
            tick();
        end
    endtask

    // other tags, ready operands and a same-cycle push stay untouched
    task automatic stale_tag_hold();
        entry_t a;
        entry_t c;
        entry_t f;
        logic [tag_w-1:0] t;
        logic [val_w-1:0] v;
        t = tag_w'(rand_word(tag_w));
        v = rand_word(val_w);
        // leave a stale word waiting on t in every slot
        // so the slot that c lands in also matches the broadcast
        for (int k = 0; k < q_length; k++) begin
            f = rand_entry();
            f.m.op_tag = {n_ops{t}};
            f.m.wake = '1;
            push(f);
            tick();
        end
        drain();
        a = rand_entry();
        a.m.op_tag[0] = t;
        a.m.wake[0] = 1'b1;
        a.m.op_tag[1] = t ^ tag_w'(1);
        a.m.wake[1] = 1'b1;
        a.m.op_tag[2] = t;
        a.m.wake[2] = 1'b0;
        a.m.op_tag[3] = t ^ tag_w'(2);
        a.m.wake[3] = 1'b0;
        push(a);
        tick();
        // every operand of c waits on the broadcast tag
        c = rand_entry();
        c.m.op_tag = {n_ops{t}};
        c.m.wake = '1;
        push(c);
        broadcast(t, v);
        tick();
        assert (dout.m.op_val[0] === v) else begin
            $display("ERROR dout.m.op_val[0] expected %h actual %h", v, dout.m.op_val[0]);
            errors++;
        end
        assert (dout.m.op_val[3:1] === a.m.op_val[3:1]) else begin
            $display("ERROR dout.m.op_val[3:1] expected %h actual %h",
                     a.m.op_val[3:1], dout.m.op_val[3:1]);
            errors++;
        end
        assert (dout.m.wake === 4'b0010) else begin
            $display("ERROR dout.m.wake expected %h actual %h", 4'b0010, dout.m.wake);
            errors++;
        end
        rd = 1'b1;
        tick();
        assert (dout.m === c.m) else begin
            $display("ERROR dout.m expected %h actual %h", c.m, dout.m);
            errors++;
        end
        rd = 1'b1;
        tick();
    endtask

    task automatic flush_restart();
        for (int k = 0; k < 5; k++) begin
            push(rand_entry());
            tick();
        end
        rd = 1'b1;
        tick();
        clr = 1'b1;
        tick();
        assert (empty === 1'b1) else begin
            $display("ERROR empty expected %h actual %h", 1'b1, empty);
            errors++;
        end
        // normal order again from the reset pointers
        for (int k = 0; k < 3; k++) begin
            push(rand_entry());
            tick();
        end
        push(rand_entry());
        rd = 1'b1;
        tick();
        drain();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        clr = 1'b0;
        wr = 1'b0;
        rd = 1'b0;
        m_din = '0;
        n_din = '0;
        result = '0;
        tick();
        tick();
        rst_n = 1'b1;
        finish_test("reset");

        random_traffic();
        finish_test("fifo_order");
        fill_and_drain();
        finish_test("flags_backpressure");
        broadcast_wakeup();
        finish_test("wakeup");
        stale_tag_hold();
        finish_test("no_false_wakeup");
        flush_restart();
        finish_test("clear");

        $display("tests passed %0d failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/mem_ex_latches_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ex_latches_chk (
    input logic clk,
    input logic rst_n,
    input logic clr,
    input logic wr,
    input logic rd,
    input logic full,
    input logic empty
);

    // strobes that actually move the queue
    logic wr_en;
    logic rd_en;

    assign wr_en = wr && !full;
    assign rd_en = rd && !empty;

    // the two flags exclude each other
    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty))
        else $error("full and empty are high together");

    // reset or flush always leaves an empty queue
    empty_after_flush: assert property (@(posedge clk)
        (!rst_n || clr) |=> empty)
        else $error("queue not empty after reset or clear");

    // a single push or pop moves the count by one
    // with eight slots only one flag can toggle
    one_flag_per_step: assert property (@(posedge clk) disable iff (!rst_n)
        (!clr && (wr_en != rd_en))
        |=> !((full != $past(full)) && (empty != $past(empty))))
        else $error("full and empty changed in the same cycle");

endmodule

`default_nettype wire

// File: rtl/mem_ex_latches.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ex_latches (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clr,
    input  logic                        wr,
    input  logic                        rd,
    input  mem_ex_pkg::mod_fields_t     m_din,
    input  mem_ex_pkg::fixed_fields_t   n_din,
    input  mem_ex_pkg::result_t         result,
    output logic                        full,
    output logic                        empty,
    output mem_ex_pkg::entry_t          dout
);

    import mem_ex_pkg::*;

    // current modifiable part of every slot
    mod_vec_t old_m_vector;
    // same after wakeup substitution
    mod_vec_t new_m_vector;
    // slots to rewrite at the next edge
    logic [q_length-1:0] modify_vector;

    // storage, pointers and flags
    queue_nm u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .clr           (clr),
        .wr            (wr),
        .rd            (rd),
        .m_din         (m_din),
        .n_din         (n_din),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_m_vector),
        .dout          (dout)
    );

    // combinational tag match against the ex broadcast
    // loop closes through the queue registers, one cycle
    operand_wakeup u_wakeup (
        .old_m_vector  (old_m_vector),
        .result        (result),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector)
    );

endmodule

`default_nettype wire

// File: rtl/operand_wakeup.sv
`timescale 1ns/100ps
`default_nettype none

module operand_wakeup (
    input  mem_ex_pkg::mod_vec_t              old_m_vector,
    input  mem_ex_pkg::result_t               result,
    output mem_ex_pkg::mod_vec_t              new_m_vector,
    output logic [mem_ex_pkg::q_length-1:0]   modify_vector
);

    import mem_ex_pkg::*;

    // one bit per slot and operand
    // set when that operand picks up the broadcast
    logic [q_length-1:0][n_ops-1:0] hit;

    // tag compare
    // slot occupancy not checked, stale slots get overwritten on push
    always_comb begin
        for (int i = 0; i < q_length; i++) begin
            for (int j = 0; j < n_ops; j++) begin
                // still waiting and waiting on this producer
                hit[i][j] = result.valid
                         && old_m_vector[i].wake[j]
                         && (old_m_vector[i].op_tag[j] == result.tag);
            end
        end
    end

    // build replacement words
    // untouched fields pass through so a whole slot can be rewritten
    always_comb begin
        new_m_vector = old_m_vector;
        for (int i = 0; i < q_length; i++) begin
            for (int j = 0; j < n_ops; j++) begin
                if (hit[i][j]) begin
                    // forward the value
                    new_m_vector[i].op_val[j] = result.value;
                    // operand now ready
                    new_m_vector[i].wake[j]   = 1'b0;
                end
            end
        end
    end

    // a slot is rewritten when any of its operands woke up
    always_comb begin
        for (int i = 0; i < q_length; i++) begin
            modify_vector[i] = |hit[i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/queue_nm.sv
`timescale 1ns/100ps
`default_nettype none

module queue_nm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clr,
    input  logic                              wr,
    input  logic                              rd,
    input  mem_ex_pkg::mod_fields_t           m_din,
    input  mem_ex_pkg::fixed_fields_t         n_din,
    input  mem_ex_pkg::mod_vec_t              new_m_vector,
    input  logic [mem_ex_pkg::q_length-1:0]   modify_vector,
    output logic                              full,
    output logic                              empty,
    output mem_ex_pkg::mod_vec_t              old_m_vector,
    output mem_ex_pkg::entry_t                dout
);

    import mem_ex_pkg::*;

    // pointer and occupancy widths
    localparam int ptr_w = $clog2(q_length);
    localparam int cnt_w = ptr_w + 1;

    // modifiable part of every slot, one packed vector
    mod_vec_t m_mem;
    // fixed part of every slot
    fixed_fields_t n_mem [q_length];

    // head and tail
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    // entries currently held
    logic [cnt_w-1:0] count;

    // strobes after flag gating
    logic wr_en;
    logic rd_en;

    // advance with wrap at the last slot
    // also correct for a depth that is not a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(q_length - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // flags straight from the count
    assign full  = (count == cnt_w'(q_length));
    assign empty = (count == '0);

    // full blocks a push even alongside a pop
    assign wr_en = wr && !full;
    // pop of an empty queue is dropped
    assign rd_en = rd && !empty;

    // pointers and count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            // branch recovery flush
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // count moves only when exactly one side acts
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // modifiable storage
    // a push into the slot wins over a wakeup of that slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < q_length; i++) begin
            if (wr_en && (wr_ptr == ptr_w'(i))) begin
                m_mem[i] <= m_din;
            end else if (modify_vector[i]) begin
                m_mem[i] <= new_m_vector[i];
            end
        end
    end

    // fixed storage, only written on push
    always_ff @(posedge clk) begin
        if (wr_en) begin
            n_mem[wr_ptr] <= n_din;
        end
    end

    // every slot goes out to the wakeup compare
    assign old_m_vector = m_mem;

    // first word fall through
    // head is visible the edge after it was pushed
    always_comb begin
        dout.m = m_mem[rd_ptr];
        dout.n = n_mem[rd_ptr];
    end

endmodule

`default_nettype wire

// File: rtl/mem_ex_pkg.sv
`default_nettype none

package mem_ex_pkg;

    // queue geometry
    // number of slots between mem and ex
    localparam int q_length = 8;

    // operand datapath
    // value width of a single operand
    localparam int val_w = 32;
    // producer tag, shrunk down from the full ptcinfo record
    localparam int tag_w = 7;
    // source operands carried per micro-op
    localparam int n_ops = 4;

    // modifiable part of an entry
    // rewritten in place while the entry waits in the queue
    typedef struct packed {
        // id of this micro-op
        logic [tag_w-1:0] ptcid;
        // one bit per operand, set while still waiting
        logic [n_ops-1:0] wake;
        // operand values, index 0 is op1
        logic [n_ops-1:0][val_w-1:0] op_val;
        // tag of the producer each operand waits on
        logic [n_ops-1:0][tag_w-1:0] op_tag;
        // micro-op valid from mem
        logic valid;
    } mod_fields_t;

    // non-modifiable part of an entry
    // written once on push, never touched by wakeup
    typedef struct packed {
        // instruction pointer
        logic [31:0] eip;
        // operand size code
        logic [1:0] opsize;
        // alu function select
        logic [4:0] aluk;
        // destination address
        logic [31:0] dest_addr;
        // branch micro-op
        logic is_br;
        // memory destination
        logic is_mem;
        // code segment
        logic [15:0] cs;
        // flags this op may update
        logic [17:0] fmask;
        // condition select for cmov/jcc style ops
        logic [1:0] conditionals;
    } fixed_fields_t;

    // one full queue word
    // modifiable part in the upper bits, fixed part below
    typedef struct packed {
        mod_fields_t m;
        fixed_fields_t n;
    } entry_t;

    // modifiable parts of all slots side by side
    // slot i sits at index i
    typedef mod_fields_t [q_length-1:0] mod_vec_t;

    // result broadcast from execute
    typedef struct packed {
        // broadcast present this cycle
        logic valid;
        // producer tag being completed
        logic [tag_w-1:0] tag;
        // produced value
        logic [val_w-1:0] value;
    } result_t;

endpackage

`default_nettype wire
